/* build.f */
+incdir+.
logic/cluster_pkg.sv
logic/dma_req_if.sv
logic/cluster_regs.sv
logic/dma_req_queues.sv
logic/dma_status_collect.sv
logic/cluster_shell_top.sv
verification/tb_cluster_shell.sv

/* Bender.yml */
package:
  name: cluster_shell

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - logic/cluster_pkg.sv
      - logic/dma_req_if.sv
      - logic/cluster_regs.sv
      - logic/dma_req_queues.sv
      - logic/dma_status_collect.sv
      - logic/cluster_shell_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - verification/tb_cluster_shell.sv

/* verification/tb_cluster_shell.sv */
// Random-stimulus testbench for the cluster control shell
// Models the register map, per-group request order and busy completion counts
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module tb_cluster_shell
  import cluster_pkg::*;
();

  localparam int NG              = `CL_NUM_GROUPS;
  localparam int N_ROUNDS        = 8;
  localparam int N_LAUNCH        = 24;
  localparam int N_BUSY          = 10;
  localparam int N_ERR           = 8;
  localparam int WRAP_PULSES     = 260;
  localparam int N_ACCESS        = N_ROUNDS * 12 + N_LAUNCH * 4 + 4 * 4 + N_BUSY * 5 + N_ERR * 7;
  localparam int WATCHDOG_CYCLES = 20 * N_ACCESS + 1000;

  logic                       clk_i;
  logic                       rst_n_i;
  reg_addr_t                  s_axi_awaddr_i;
  logic                       s_axi_awvalid_i;
  logic                       s_axi_awready_o;
  reg_data_t                  s_axi_wdata_i;
  logic [3:0]                 s_axi_wstrb_i;
  logic                       s_axi_wvalid_i;
  logic                       s_axi_wready_o;
  axi_resp_t                  s_axi_bresp_o;
  logic                       s_axi_bvalid_o;
  logic                       s_axi_bready_i;
  reg_addr_t                  s_axi_araddr_i;
  logic                       s_axi_arvalid_i;
  logic                       s_axi_arready_o;
  reg_data_t                  s_axi_rdata_o;
  axi_resp_t                  s_axi_rresp_o;
  logic                       s_axi_rvalid_o;
  logic                       s_axi_rready_i;
  core_mask_t                 wake_up_o;
  addr_t                      ro_start_o;
  addr_t                      ro_end_o;
  addr_t [`CL_NUM_GROUPS-1:0] dma_src_o;
  addr_t [`CL_NUM_GROUPS-1:0] dma_dst_o;
  len_t  [`CL_NUM_GROUPS-1:0] dma_len_o;
  group_mask_t                dma_valid_o;
  group_mask_t                dma_ready_i;
  group_mask_t                dma_busy_i;

  // Model state
  reg_data_t   mdl_ro_start;
  reg_data_t   mdl_ro_end;
  reg_data_t   mdl_src;
  reg_data_t   mdl_dst;
  reg_data_t   mdl_len;
  group_mask_t busy_mdl;
  done_cnt_t   done_mdl [NG];
  group_idx_t  q_grp [$];
  addr_t       q_src [$];
  addr_t       q_dst [$];
  len_t        q_len [$];

  group_mask_t ready_pat [64];
  logic        ready_rand;
  group_mask_t ready_force;
  int unsigned cyc;
  logic        wake_pending;
  core_mask_t  wake_exp;
  int          pass_cnt;
  int          fail_cnt;
  int          test_base;

  cluster_shell_top uut (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // Group ready follows either the random pattern or a forced mask
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    dma_ready_i <= ready_rand ? ready_pat[cyc % 64] : ready_force;
  end

  task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_mask(input string name, input core_mask_t got, input core_mask_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_req(input int g, input addr_t src, input addr_t dst, input len_t len,
                           input addr_t e_src, input addr_t e_dst, input len_t e_len);
    if (src !== e_src || dst !== e_dst || len !== e_len) begin
      $display("Fail dma request group %0d: got src %h dst %h len %h expected src %h dst %h len %h",
               g, src, dst, len, e_src, e_dst, e_len);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Oldest outstanding request of this group must be the one leaving
  task automatic pop_check(input int g);
    int idx;
    int i;
    idx = -1;
    for (i = 0; i < q_grp.size(); i++) begin
      if (idx < 0 && q_grp[i] == group_idx_t'(g)) idx = i;
    end
    if (idx < 0) begin
      $display("Group %0d issued a request that was never launched", g);
      fail_cnt++;
    end else begin
      check_req(g, dma_src_o[g], dma_dst_o[g], dma_len_o[g], q_src[idx], q_dst[idx], q_len[idx]);
      q_grp.delete(idx);
      q_src.delete(idx);
      q_dst.delete(idx);
      q_len.delete(idx);
    end
  endtask

  always @(posedge clk_i) begin
    for (int g = 0; g < NG; g++) begin
      if (rst_n_i && dma_valid_o[g] && dma_ready_i[g]) pop_check(g);
    end
  end

  // Wake-up must pulse only in the cycle after a WAKE write is taken
  always @(posedge clk_i) begin
    if (wake_pending) begin
      check_mask("wake_up_o", wake_up_o, wake_exp);
    end else if (wake_up_o !== '0) begin
      check_mask("wake_up_o", wake_up_o, '0);
    end
    wake_pending = s_axi_awready_o && (s_axi_awaddr_i == `CL_REG_WAKE);
    wake_exp     = core_mask_t'(s_axi_wdata_i);
  end

  function automatic void model_read(input reg_addr_t a, output reg_data_t d,
                                     output axi_resp_t r);
    int idx;
    idx = (int'(a) - int'(`CL_REG_DMA_DONE0)) / 4;
    d = '0;
    r = RESP_OKAY;
    case (a)
      `CL_REG_WAKE, `CL_REG_DMA_LAUNCH: d = '0;
      `CL_REG_RO_START: d = mdl_ro_start;
      `CL_REG_RO_END:   d = mdl_ro_end;
      `CL_REG_DMA_SRC:  d = mdl_src;
      `CL_REG_DMA_DST:  d = mdl_dst;
      `CL_REG_DMA_LEN:  d = mdl_len;
      `CL_REG_DMA_BUSY: d = reg_data_t'(busy_mdl);
      default: begin
        if (a[1:0] == 2'b00 && idx >= 0 && idx < NG && a >= `CL_REG_DMA_DONE0) begin
          d = reg_data_t'(done_mdl[idx]);
        end else begin
          r = RESP_SLVERR;
        end
      end
    endcase
  endfunction

  function automatic axi_resp_t model_wr_resp(input reg_addr_t a);
    return (a[1:0] == 2'b00 && a <= `CL_REG_DMA_LAUNCH) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  function automatic reg_addr_t cfg_addr(input int i);
    case (i)
      0:       return `CL_REG_RO_START;
      1:       return `CL_REG_RO_END;
      2:       return `CL_REG_DMA_SRC;
      3:       return `CL_REG_DMA_DST;
      default: return `CL_REG_DMA_LEN;
    endcase
  endfunction

  task automatic write_issue(input reg_addr_t a, input reg_data_t d);
    @(posedge clk_i);
    s_axi_awaddr_i  <= a;
    s_axi_awvalid_i <= 1'b1;
    s_axi_wdata_i   <= d;
    s_axi_wvalid_i  <= 1'b1;
    do @(posedge clk_i); while (!s_axi_awready_o);
    // W is taken in the same cycle as AW
    if (s_axi_wready_o !== 1'b1) begin
      $display("W channel was not taken together with AW at offset %h", a);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
    s_axi_awvalid_i <= 1'b0;
    s_axi_wvalid_i  <= 1'b0;
  endtask

  task automatic wait_bresp(output axi_resp_t r);
    s_axi_bready_i <= 1'b1;
    do @(posedge clk_i); while (!s_axi_bvalid_o);
    r = s_axi_bresp_o;
    s_axi_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input reg_addr_t a, output reg_data_t d, output axi_resp_t r);
    @(posedge clk_i);
    s_axi_araddr_i  <= a;
    s_axi_arvalid_i <= 1'b1;
    s_axi_rready_i  <= 1'b1;
    do @(posedge clk_i); while (!s_axi_arready_o);
    s_axi_arvalid_i <= 1'b0;
    do @(posedge clk_i); while (!s_axi_rvalid_o);
    d = s_axi_rdata_o;
    r = s_axi_rresp_o;
    s_axi_rready_i <= 1'b0;
  endtask

  task automatic reg_write(input reg_addr_t a, input reg_data_t d);
    axi_resp_t r;
    write_issue(a, d);
    wait_bresp(r);
    check_resp($sformatf("bresp[%h]", a), r, model_wr_resp(a));
    case (a)
      `CL_REG_RO_START: mdl_ro_start = d;
      `CL_REG_RO_END:   mdl_ro_end = d;
      `CL_REG_DMA_SRC:  mdl_src = d;
      `CL_REG_DMA_DST:  mdl_dst = d;
      `CL_REG_DMA_LEN:  mdl_len = {16'h0, d[15:0]};
      default: ;
    endcase
  endtask

  task automatic reg_read_check(input reg_addr_t a);
    reg_data_t d;
    reg_data_t e_d;
    axi_resp_t r;
    axi_resp_t e_r;
    axi_read(a, d, r);
    model_read(a, e_d, e_r);
    check_data($sformatf("rdata[%h]", a), d, e_d);
    check_resp($sformatf("rresp[%h]", a), r, e_r);
  endtask

  task automatic check_cfg();
    for (int i = 0; i < 5; i++) reg_read_check(cfg_addr(i));
    check_data("ro_start_o", ro_start_o, mdl_ro_start);
    check_data("ro_end_o", ro_end_o, mdl_ro_end);
  endtask

  // Stages a random request and takes the LAUNCH write without collecting B
  task automatic launch_issue(input group_idx_t g);
    addr_t src;
    addr_t dst;
    len_t  len;
    src = $urandom;
    dst = $urandom;
    len = len_t'($urandom);
    reg_write(`CL_REG_DMA_SRC, src);
    reg_write(`CL_REG_DMA_DST, dst);
    reg_write(`CL_REG_DMA_LEN, reg_data_t'(len));
    write_issue(`CL_REG_DMA_LAUNCH, reg_data_t'(g) | ($urandom & 32'hFFFF_FFFC));
    q_grp.push_back(g);
    q_src.push_back(src);
    q_dst.push_back(dst);
    q_len.push_back(len);
  endtask

  task automatic launch(input group_idx_t g);
    axi_resp_t r;
    launch_issue(g);
    wait_bresp(r);
    check_resp("bresp[launch]", r, RESP_OKAY);
  endtask

  task automatic wait_drain();
    ready_rand  <= 1'b0;
    ready_force <= '1;
    while (q_grp.size() != 0) @(posedge clk_i);
  endtask

  task automatic drive_busy(input group_mask_t v);
    group_mask_t falls;
    @(posedge clk_i);
    dma_busy_i <= v;
    falls = busy_mdl & ~v;
    for (int g = 0; g < NG; g++) done_mdl[g] = done_mdl[g] + done_cnt_t'(falls[g]);
    busy_mdl = v;
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d failing checks", name, fail_cnt - test_base);
    test_base = fail_cnt;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    reg_data_t   d;
    axi_resp_t   r;
    reg_addr_t   a;
    group_idx_t  g;
    group_idx_t  h;
    void'($urandom(32'h16f4_9e02));
    for (int i = 0; i < 64; i++) ready_pat[i] = group_mask_t'($urandom);
    rst_n_i = 1'b0;
    s_axi_awaddr_i = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i = '0;
    s_axi_wstrb_i = 4'hF;
    s_axi_wvalid_i = 1'b0;
    s_axi_bready_i = 1'b0;
    s_axi_araddr_i = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i = 1'b0;
    dma_ready_i = '0;
    dma_busy_i = '0;
    ready_rand = 1'b0;
    ready_force = '1;
    cyc = 0;
    wake_pending = 1'b0;
    wake_exp = '0;
    pass_cnt = 0;
    fail_cnt = 0;
    test_base = 0;
    mdl_ro_start = `CL_RO_START_RST;
    mdl_ro_end = `CL_RO_END_RST;
    mdl_src = '0;
    mdl_dst = '0;
    mdl_len = '0;
    busy_mdl = '0;
    for (int i = 0; i < NG; i++) done_mdl[i] = '0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    check_data("ro_start_o", ro_start_o, `CL_RO_START_RST);
    check_data("ro_end_o", ro_end_o, `CL_RO_END_RST);
    for (int n = 0; n < N_ROUNDS; n++) begin
      for (int i = 0; i < 5; i++) reg_write(cfg_addr(i), $urandom);
      check_cfg();
    end
    end_test("reset and cache window");

    for (int n = 0; n < N_ROUNDS; n++) begin
      reg_write(`CL_REG_WAKE, $urandom | 32'h1);
      reg_read_check(`CL_REG_WAKE);
    end
    end_test("wake-up pulse");

    ready_rand <= 1'b1;
    for (int n = 0; n < N_LAUNCH; n++) launch(group_idx_t'($urandom));
    wait_drain();
    end_test("dma routing and order");

    // Fill one group, show another still launches, then stall the third
    g = group_idx_t'($urandom);
    h = g + 1'b1;
    ready_force <= ~(group_mask_t'(1) << g);
    repeat (2) @(posedge clk_i);
    launch(g);
    launch(g);
    launch(h);
    launch_issue(g);
    repeat (8) begin
      @(posedge clk_i);
      if (s_axi_bvalid_o) begin
        $display("B response came back while group %0d was full", g);
        fail_cnt++;
      end
    end
    ready_force <= '1;
    wait_bresp(r);
    check_resp("bresp[launch]", r, RESP_OKAY);
    wait_drain();
    end_test("back-pressure");

    repeat (WRAP_PULSES) begin
      drive_busy('1);
      drive_busy('0);
    end
    for (int n = 0; n < N_BUSY; n++) begin
      repeat (6) drive_busy(group_mask_t'($urandom));
      repeat (4) @(posedge clk_i);
      reg_read_check(`CL_REG_DMA_BUSY);
      for (int i = 0; i < NG; i++) reg_read_check(`CL_REG_DMA_DONE0 + reg_addr_t'(4 * i));
    end
    end_test("status and counts");

    for (int n = 0; n < N_ERR; n++) begin
      do begin
        a = reg_addr_t'($urandom);
        model_read(a, d, r);
      end while (r != RESP_SLVERR);
      reg_read_check(a);
      case ($urandom % 3)
        0:       a = `CL_REG_DMA_BUSY;
        1:       a = `CL_REG_DMA_DONE0 + reg_addr_t'(4 * ($urandom % NG));
        default: a = a;
      endcase
      reg_write(a, $urandom);
      check_cfg();
    end
    end_test("error responses");

    $display("Check count: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/cluster_shell_top.sv */
// Cluster control shell with an AXI4-Lite slave for configuration
// Write strobes are ignored, every write is full-word
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_shell_top
  import cluster_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  // AXI4-Lite slave
  input  wire reg_addr_t                      s_axi_awaddr_i,
  input  wire logic                           s_axi_awvalid_i,
  output      logic                           s_axi_awready_o,
  input  wire reg_data_t                      s_axi_wdata_i,
  input  wire logic [3:0]                     s_axi_wstrb_i,
  input  wire logic                           s_axi_wvalid_i,
  output      logic                           s_axi_wready_o,
  output      axi_resp_t                      s_axi_bresp_o,
  output      logic                           s_axi_bvalid_o,
  input  wire logic                           s_axi_bready_i,
  input  wire reg_addr_t                      s_axi_araddr_i,
  input  wire logic                           s_axi_arvalid_i,
  output      logic                           s_axi_arready_o,
  output      reg_data_t                      s_axi_rdata_o,
  output      axi_resp_t                      s_axi_rresp_o,
  output      logic                           s_axi_rvalid_o,
  input  wire logic                           s_axi_rready_i,
  // Cores and groups
  output      core_mask_t                     wake_up_o,
  output      addr_t                          ro_start_o,
  output      addr_t                          ro_end_o,
  output      addr_t [`CL_NUM_GROUPS-1:0]     dma_src_o,
  output      addr_t [`CL_NUM_GROUPS-1:0]     dma_dst_o,
  output      len_t  [`CL_NUM_GROUPS-1:0]     dma_len_o,
  output      group_mask_t                    dma_valid_o,
  input  wire group_mask_t                    dma_ready_i,
  input  wire group_mask_t                    dma_busy_i
);

  group_mask_t                    busy_q;
  done_cnt_t [`CL_NUM_GROUPS-1:0] done_cnt;

  dma_req_if req_if ();

  cluster_regs i_regs (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .wake_up_o       (wake_up_o),
    .ro_start_o      (ro_start_o),
    .ro_end_o        (ro_end_o),
    .req             (req_if),
    .busy_i          (busy_q),
    .done_cnt_i      (done_cnt)
  );

  dma_req_queues i_queues (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req         (req_if),
    .dma_src_o   (dma_src_o),
    .dma_dst_o   (dma_dst_o),
    .dma_len_o   (dma_len_o),
    .dma_valid_o (dma_valid_o),
    .dma_ready_i (dma_ready_i)
  );

  dma_status_collect i_status (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .dma_busy_i (dma_busy_i),
    .busy_o     (busy_q),
    .done_cnt_o (done_cnt)
  );

endmodule

`default_nettype wire

/* logic/dma_status_collect.sv */
// Group busy flags, registered once, and per-group completion counters
// Busy inputs must already be in the shell clock domain, counters wrap
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module dma_status_collect
  import cluster_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  input  wire group_mask_t                     dma_busy_i,
  output      group_mask_t                     busy_o,
  output      done_cnt_t [`CL_NUM_GROUPS-1:0]  done_cnt_o
);

  group_mask_t                    busy_q;
  group_mask_t                    busy_d_q;
  group_mask_t                    busy_fall;
  done_cnt_t [`CL_NUM_GROUPS-1:0] done_cnt_q;

  // Falling edge of the registered flag ends one transfer
  assign busy_fall = busy_d_q & ~busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= '0;
      busy_d_q   <= '0;
      done_cnt_q <= '0;
    end else begin
      busy_q   <= dma_busy_i;
      busy_d_q <= busy_q;
      for (int g = 0; g < `CL_NUM_GROUPS; g++) begin
        if (busy_fall[g]) begin
          done_cnt_q[g] <= done_cnt_q[g] + done_cnt_t'(1);
        end
      end
    end
  end

  assign busy_o     = busy_q;
  assign done_cnt_o = done_cnt_q;

endmodule

`default_nettype wire

/* logic/dma_req_queues.sv */
// Per-group DMA request buffers, two entries each, order kept within a group
// A full group only back-pressures launches addressed to it
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module dma_req_queues
  import cluster_pkg::*;
(
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  dma_req_if.dst                              req,
  output      addr_t [`CL_NUM_GROUPS-1:0]     dma_src_o,
  output      addr_t [`CL_NUM_GROUPS-1:0]     dma_dst_o,
  output      len_t  [`CL_NUM_GROUPS-1:0]     dma_len_o,
  output      group_mask_t                    dma_valid_o,
  input  wire group_mask_t                    dma_ready_i
);

  group_mask_t spill_free;

  assign req.ready = spill_free[req.group];

  for (genvar g = 0; g < `CL_NUM_GROUPS; g++) begin : gen_group
    logic  in_fire;
    logic  out_fire;
    logic  main_valid_q;
    logic  spill_valid_q;
    addr_t main_src_q;
    addr_t main_dst_q;
    len_t  main_len_q;
    addr_t spill_src_q;
    addr_t spill_dst_q;
    len_t  spill_len_q;

    assign in_fire  = req.valid && (req.group == group_idx_t'(g)) && !spill_valid_q;
    assign out_fire = main_valid_q && dma_ready_i[g];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        main_valid_q  <= 1'b0;
        spill_valid_q <= 1'b0;
      end else if (!main_valid_q || out_fire) begin
        // Main slot refills from the spill slot first
        if (spill_valid_q) begin
          main_valid_q  <= 1'b1;
          spill_valid_q <= 1'b0;
        end else begin
          main_valid_q <= in_fire;
        end
      end else if (in_fire) begin
        spill_valid_q <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!main_valid_q || out_fire) begin
        if (spill_valid_q) begin
          main_src_q <= spill_src_q;
          main_dst_q <= spill_dst_q;
          main_len_q <= spill_len_q;
        end else if (in_fire) begin
          main_src_q <= req.src_addr;
          main_dst_q <= req.dst_addr;
          main_len_q <= req.len;
        end
      end else if (in_fire) begin
        spill_src_q <= req.src_addr;
        spill_dst_q <= req.dst_addr;
        spill_len_q <= req.len;
      end
    end

    assign spill_free[g]  = !spill_valid_q;
    assign dma_valid_o[g] = main_valid_q;
    assign dma_src_o[g]   = main_src_q;
    assign dma_dst_o[g]   = main_dst_q;
    assign dma_len_o[g]   = main_len_q;
  end

endmodule

`default_nettype wire

/* logic/cluster_regs.sv */
// AXI4-Lite register file of the cluster shell with one write and one read in flight
// Write strobes are not used and every write is full-word
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_regs
  import cluster_pkg::*;
(
  input  wire logic                            clk_i,
  input  wire logic                            rst_n_i,
  // AXI4-Lite slave
  input  wire reg_addr_t                       s_axi_awaddr_i,
  input  wire logic                            s_axi_awvalid_i,
  output      logic                            s_axi_awready_o,
  input  wire reg_data_t                       s_axi_wdata_i,
  input  wire logic                            s_axi_wvalid_i,
  output      logic                            s_axi_wready_o,
  output      axi_resp_t                       s_axi_bresp_o,
  output      logic                            s_axi_bvalid_o,
  input  wire logic                            s_axi_bready_i,
  input  wire reg_addr_t                       s_axi_araddr_i,
  input  wire logic                            s_axi_arvalid_i,
  output      logic                            s_axi_arready_o,
  output      reg_data_t                       s_axi_rdata_o,
  output      axi_resp_t                       s_axi_rresp_o,
  output      logic                            s_axi_rvalid_o,
  input  wire logic                            s_axi_rready_i,
  // Control outputs
  output      core_mask_t                      wake_up_o,
  output      addr_t                           ro_start_o,
  output      addr_t                           ro_end_o,
  dma_req_if.src                               req,
  // Status
  input  wire group_mask_t                     busy_i,
  input  wire done_cnt_t [`CL_NUM_GROUPS-1:0]  done_cnt_i
);

  localparam reg_addr_t done_last_addr =
    `CL_REG_DMA_DONE0 + reg_addr_t'(4 * (`CL_NUM_GROUPS - 1));

  regs_wr_state_e wr_state_q;
  logic           wr_fire;
  logic           wr_err;
  axi_resp_t      bresp_q;
  group_idx_t     launch_group_q;

  core_mask_t     wake_q;
  addr_t          ro_start_q;
  addr_t          ro_end_q;
  addr_t          dma_src_q;
  addr_t          dma_dst_q;
  len_t           dma_len_q;

  logic           rd_fire;
  logic           rvalid_q;
  reg_data_t      rdata_q;
  axi_resp_t      rresp_q;
  reg_data_t      rd_data;
  axi_resp_t      rd_resp;
  group_idx_t     done_idx;

  // AW and W are taken together and only from idle
  assign wr_fire = s_axi_awvalid_i && s_axi_wvalid_i && (wr_state_q == WR_IDLE);

  always_comb begin
    case (s_axi_awaddr_i)
      `CL_REG_WAKE, `CL_REG_RO_START, `CL_REG_RO_END, `CL_REG_DMA_SRC,
      `CL_REG_DMA_DST, `CL_REG_DMA_LEN, `CL_REG_DMA_LAUNCH: wr_err = 1'b0;
      default: wr_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_IDLE;
      wake_q     <= '0;
      ro_start_q <= `CL_RO_START_RST;
      ro_end_q   <= `CL_RO_END_RST;
      dma_src_q  <= '0;
      dma_dst_q  <= '0;
      dma_len_q  <= '0;
    end else begin
      wake_q <= (wr_fire && (s_axi_awaddr_i == `CL_REG_WAKE)) ? core_mask_t'(s_axi_wdata_i) : '0;
      case (wr_state_q)
        WR_IDLE: begin
          if (wr_fire) begin
            wr_state_q <= (s_axi_awaddr_i == `CL_REG_DMA_LAUNCH) ? WR_LAUNCH : WR_RESP;
          end
        end
        // B waits for the queue to take the request
        WR_LAUNCH: if (req.ready) wr_state_q <= WR_RESP;
        WR_RESP:   if (s_axi_bready_i) wr_state_q <= WR_IDLE;
        default:   wr_state_q <= WR_IDLE;
      endcase
      if (wr_fire) begin
        case (s_axi_awaddr_i)
          `CL_REG_RO_START: ro_start_q <= addr_t'(s_axi_wdata_i);
          `CL_REG_RO_END:   ro_end_q   <= addr_t'(s_axi_wdata_i);
          `CL_REG_DMA_SRC:  dma_src_q  <= addr_t'(s_axi_wdata_i);
          `CL_REG_DMA_DST:  dma_dst_q  <= addr_t'(s_axi_wdata_i);
          `CL_REG_DMA_LEN:  dma_len_q  <= len_t'(s_axi_wdata_i);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      bresp_q        <= wr_err ? RESP_SLVERR : RESP_OKAY;
      launch_group_q <= group_idx_t'(s_axi_wdata_i);
    end
  end

  assign s_axi_awready_o = wr_fire;
  assign s_axi_wready_o  = wr_fire;
  assign s_axi_bvalid_o  = (wr_state_q == WR_RESP);
  assign s_axi_bresp_o   = bresp_q;

  assign wake_up_o  = wake_q;
  assign ro_start_o = ro_start_q;
  assign ro_end_o   = ro_end_q;

  assign req.valid    = (wr_state_q == WR_LAUNCH);
  assign req.group    = launch_group_q;
  assign req.src_addr = dma_src_q;
  assign req.dst_addr = dma_dst_q;
  assign req.len      = dma_len_q;

  // Read decode
  always_comb begin
    rd_data  = '0;
    rd_resp  = RESP_OKAY;
    done_idx = group_idx_t'((s_axi_araddr_i - `CL_REG_DMA_DONE0) >> 2);
    case (s_axi_araddr_i)
      `CL_REG_WAKE, `CL_REG_DMA_LAUNCH: rd_data = '0;
      `CL_REG_RO_START: rd_data = reg_data_t'(ro_start_q);
      `CL_REG_RO_END:   rd_data = reg_data_t'(ro_end_q);
      `CL_REG_DMA_SRC:  rd_data = reg_data_t'(dma_src_q);
      `CL_REG_DMA_DST:  rd_data = reg_data_t'(dma_dst_q);
      `CL_REG_DMA_LEN:  rd_data = reg_data_t'(dma_len_q);
      `CL_REG_DMA_BUSY: rd_data = reg_data_t'(busy_i);
      default: begin
        if ((s_axi_araddr_i >= `CL_REG_DMA_DONE0) && (s_axi_araddr_i <= done_last_addr) &&
            (s_axi_araddr_i[1:0] == 2'b00)) begin
          rd_data = reg_data_t'(done_cnt_i[done_idx]);
        end else begin
          rd_resp = RESP_SLVERR;
        end
      end
    endcase
  end

  assign rd_fire = s_axi_arvalid_i && s_axi_arready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_rready_i) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  // Held low while in reset
  assign s_axi_arready_o = rst_n_i && !rvalid_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = rresp_q;

endmodule

`default_nettype wire

/* logic/dma_req_if.sv */
// One DMA request with valid/ready handshake
// Valid and payload hold steady from valid rise until the handshake
`timescale 1ns/1ps
`default_nettype none

interface dma_req_if
  import cluster_pkg::*;
();

  logic       valid;
  logic       ready;
  group_idx_t group;
  addr_t      src_addr;
  addr_t      dst_addr;
  len_t       len;

  modport src (output valid, group, src_addr, dst_addr, len, input ready);

  modport dst (input valid, group, src_addr, dst_addr, len, output ready);

endinterface

`default_nettype wire

/* logic/cluster_pkg.sv */
// Types shared by the shell RTL and its testbench
// Widths come from the size macros
`default_nettype none

`include "cluster_macros.svh"

package cluster_pkg;

  typedef logic [`CL_ADDR_W-1:0]             addr_t;
  typedef logic [`CL_LEN_W-1:0]              len_t;
  typedef logic [$clog2(`CL_NUM_GROUPS)-1:0] group_idx_t;
  typedef logic [`CL_NUM_GROUPS-1:0]         group_mask_t;
  typedef logic [`CL_NUM_CORES-1:0]          core_mask_t;
  typedef logic [`CL_CNT_W-1:0]              done_cnt_t;

  // AXI4-Lite register port
  typedef logic [`CL_REG_ADDR_W-1:0]         reg_addr_t;
  typedef logic [31:0]                       reg_data_t;
  typedef logic [1:0]                        axi_resp_t;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

  // Write channel of the register file
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_RESP,
    WR_LAUNCH
  } regs_wr_state_e;

endpackage

`default_nettype wire

/* cluster_macros.svh */
// Sizes and register map of the cluster control shell
// Offsets are byte addresses of 32-bit words, and only aligned offsets are mapped
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

`define CL_NUM_GROUPS       4
`define CL_CORES_PER_GROUP  4
`define CL_NUM_CORES        (`CL_NUM_GROUPS * `CL_CORES_PER_GROUP)

`define CL_ADDR_W           32
`define CL_LEN_W            16
`define CL_CNT_W            8
`define CL_REG_ADDR_W       8

// Read-only cache window after reset
`define CL_RO_START_RST     32'h8000_0000
`define CL_RO_END_RST       32'h8001_0000

`define CL_REG_WAKE         8'h00
`define CL_REG_RO_START     8'h04
`define CL_REG_RO_END       8'h08
`define CL_REG_DMA_SRC      8'h0C
`define CL_REG_DMA_DST      8'h10
`define CL_REG_DMA_LEN      8'h14
`define CL_REG_DMA_LAUNCH   8'h18
`define CL_REG_DMA_BUSY     8'h1C
`define CL_REG_DMA_DONE0    8'h20

`endif
